// File: src.f
source/dac_pkg.sv
source/dac_frame_if.sv
source/cmd_write_slave.sv
source/sclk_timer.sv
source/dac_sequencer.sv
source/dac_shifter.sv
source/convst_timer.sv
source/dac_ctrl_top.sv
verification/dac_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DAC controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module dac_ctrl_tb -f src.f -o dac_ctrl_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dac_ctrl_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Everything OK" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: verification/dac_ctrl_tb.sv
`timescale 1ns/1ps

module dac_ctrl_tb import dac_pkg::*; ();

	localparam int NUM_RAND        = 4;
	localparam int NUM_ROWS        = 7 + NUM_RAND;
	localparam int EXCH_CYCLES     = 3 * (FRAME_BITS + SYNC_SCLKS + 2) * SCLK_DIV + 50;
	localparam int GAP_LIMIT       = 16 * 64 + 1;      // Enabled rows keep voltage below 16
	localparam int QUIET_CYCLES    = 200;
	localparam int ROW_CYCLES      = EXCH_CYCLES + 2 * GAP_LIMIT + QUIET_CYCLES + 100;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + 1000;

	typedef struct {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              corrupt;   // Model inverts the echo
		logic [1:0]        resp;
		cmd_t              cmd;       // Outputs after the write
		logic              ok;
	} row_t;

	logic                sys_clk;
	logic                sys_rst;
	logic                i_awvalid;
	logic [ADDR_W-1:0]   i_awaddr;
	logic                i_wvalid;
	logic [DATA_W-1:0]   i_wdata;
	logic [DATA_W/8-1:0] i_wstrb;
	logic                i_bready;
	logic                i_sdo;
	logic                o_awready;
	logic                o_wready;
	logic                o_bvalid;
	logic [1:0]          o_bresp;
	logic                o_sclk;
	logic                o_sync_n;
	logic                o_sdin;
	logic                o_dac_reset_n;
	logic                o_dac_done;
	logic                o_dac_ok;
	logic                o_motor_enable;
	logic                o_motor_dir;
	logic                o_alarm_reset;
	logic                o_trig_convst;

	row_t        rows[$];
	dac_word_t   frames[$];            // Frames seen by the DAC model
	dac_word_t   shift_in;
	dac_word_t   echo_word = '0;       // Returned during the next frame
	voltage_t    dac_code = '0;        // Last written code
	int          nbits = 0;
	logic        corrupt_echo = 1'b0;
	logic [15:0] lfsr_state = 16'h0001;

	dac_ctrl_top uut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.o_awready(o_awready), .i_awvalid(i_awvalid), .i_awaddr(i_awaddr),
		.o_wready(o_wready), .i_wvalid(i_wvalid), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.o_bvalid(o_bvalid), .o_bresp(o_bresp), .i_bready(i_bready),
		.i_sdo(i_sdo), .o_sclk(o_sclk), .o_sync_n(o_sync_n), .o_sdin(o_sdin),
		.o_dac_reset_n(o_dac_reset_n), .o_dac_done(o_dac_done), .o_dac_ok(o_dac_ok),
		.o_motor_enable(o_motor_enable), .o_motor_dir(o_motor_dir),
		.o_alarm_reset(o_alarm_reset), .o_trig_convst(o_trig_convst)
	);

	always #5 sys_clk = ~sys_clk;

	//**************************************************
	// DAC model
	//**************************************************
	always @(negedge o_sclk) begin
		if (!o_sync_n) begin
			shift_in = {shift_in[FRAME_BITS-2:0], o_sdin};  // Sample on falling sclk
			nbits    = nbits + 1;
			#1;
			i_sdo = (nbits < FRAME_BITS) ? echo_word[FRAME_BITS-1-nbits] : 1'b0;
		end
	end

	// Frame closes when sync_n rises
	always @(posedge o_sync_n) begin
		if (nbits == FRAME_BITS) begin
			frames.push_back(shift_in);
			if (shift_in[23:20] == DAC_CMD_WRITE)
				dac_code = shift_in[15:6];
			if (shift_in[23:20] == DAC_CMD_READ)
				echo_word = {12'd0, corrupt_echo ? ~dac_code : dac_code, 2'd0};
			else
				echo_word = '0;
		end else if (nbits != 0) begin
			fail_run("DAC frame ended after a wrong number of sclk edges");
		end
		nbits = 0;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, got));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, got));
	endtask

	task automatic check_word(input string name, input dac_word_t got, input dac_word_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, got));
	endtask

	// Motor pins plus the code the DAC last received
	task automatic check_cmd(input cmd_t exp);
		cmd_t got;
		got = '{motor_en: o_motor_enable, motor_dir: o_motor_dir,
			alarm_rst: o_alarm_reset, voltage: dac_code};
		if (got !== exp)
			fail_run($sformatf("ERR %0t cmd expected %h got %h", $time, exp, got));
	endtask

	// Galois LFSR, taps 16,14,13,11
	function automatic logic lfsr_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic voltage_t rand_code();
		voltage_t v;
		for (int b = 0; b < 10; b++)
			v[b] = lfsr_bit();
		return v;
	endfunction

	// Keys at 63:48, 47:32, 15:0 and code at 25:16
	function automatic logic [DATA_W-1:0] cmd_word(input logic [15:0] en, input logic [15:0] fwd,
			input logic [15:0] alm, input voltage_t v);
		return {en, fwd, 6'd0, v, alm};
	endfunction

	function automatic cmd_t make_cmd(input logic en, input logic dir, input logic alm,
			input voltage_t v);
		return '{motor_en: en, motor_dir: dir, alarm_rst: alm, voltage: v};
	endfunction

	function automatic void add_row(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic corrupt, input logic [1:0] resp, input cmd_t cmd, input logic ok);
		row_t r;
		r.addr    = addr;
		r.data    = data;
		r.corrupt = corrupt;
		r.resp    = resp;
		r.cmd     = cmd;
		r.ok      = ok;
		rows.push_back(r);
	endfunction

	//**************************************************
	// Bus and phase tasks
	//**************************************************
	task automatic check_reset_phase();
		int   cyc;
		int   first_fall;
		int   last_fall;
		logic prev_sclk;
		cyc        = 0;
		first_fall = -1;
		last_fall  = -1;
		prev_sclk  = 1'b0;
		@(negedge sys_clk);
		check_bit("o_sync_n", o_sync_n, 1'b1);
		check_bit("o_bvalid", o_bvalid, 1'b0);
		check_bit("o_dac_done", o_dac_done, 1'b0);
		check_bit("o_motor_enable", o_motor_enable, 1'b0);
		check_bit("o_motor_dir", o_motor_dir, 1'b1);
		check_bit("o_alarm_reset", o_alarm_reset, 1'b0);
		check_bit("o_trig_convst", o_trig_convst, 1'b0);
		while (!o_dac_reset_n) begin
			check_bit("o_awready", o_awready, 1'b0);    // No commands during DAC reset
			check_bit("o_wready", o_wready, 1'b0);
			if (prev_sclk && !o_sclk) begin
				if (first_fall < 0)
					first_fall = cyc;
				last_fall = cyc;
			end
			prev_sclk = o_sclk;
			cyc++;
			if (cyc > 3 * RESET_SCLKS * SCLK_DIV)
				fail_run("DAC reset line never went high");
			@(negedge sys_clk);
		end
		// Five falls span four whole sclk periods
		check_count("reset_n low span", last_fall - first_fall, RESET_SCLKS * SCLK_DIV);
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input int hold, output logic [1:0] resp);
		logic aw_hs;
		logic w_hs;
		int   cyc;
		@(posedge sys_clk);
		#1;
		i_awaddr  = addr;
		i_awvalid = 1'b1;
		i_wdata   = data;
		i_wvalid  = 1'b1;
		cyc       = 0;
		while (i_awvalid || i_wvalid) begin
			@(negedge sys_clk);
			aw_hs = i_awvalid && o_awready;
			w_hs  = i_wvalid && o_wready;
			@(posedge sys_clk);
			#1;
			if (aw_hs)
				i_awvalid = 1'b0;
			if (w_hs)
				i_wvalid = 1'b0;
			cyc++;
			if (cyc > EXCH_CYCLES)
				fail_run("Write address or data was never accepted");
		end
		cyc = 0;
		@(negedge sys_clk);
		while (!o_bvalid) begin
			cyc++;
			if (cyc > 20)
				fail_run("No write response after both channels completed");
			@(negedge sys_clk);
		end
		// Back-pressure on B, a second write must stall
		repeat (hold) begin
			@(posedge sys_clk);
			#1;
			i_awaddr  = ~addr;
			i_awvalid = 1'b1;
			i_wvalid  = 1'b1;
			@(negedge sys_clk);
			check_bit("o_bvalid", o_bvalid, 1'b1);
			check_bit("o_awready", o_awready, 1'b0);
			check_bit("o_wready", o_wready, 1'b0);
		end
		@(posedge sys_clk);
		#1;
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		i_bready  = 1'b1;
		@(negedge sys_clk);
		check_bit("o_bvalid", o_bvalid, 1'b1);
		resp = o_bresp;
		@(posedge sys_clk);
		#1;
		i_bready = 1'b0;
		@(negedge sys_clk);
		check_bit("o_bvalid", o_bvalid, 1'b0);
	endtask

	task automatic wait_dac_done(output logic ok);
		int cyc;
		cyc = 0;
		@(negedge sys_clk);
		while (!o_dac_done) begin
			cyc++;
			if (cyc > EXCH_CYCLES)
				fail_run("DAC exchange did not finish in time");
			@(negedge sys_clk);
		end
		ok = o_dac_ok;
	endtask

	task automatic check_convst(input cmd_t exp);
		int cyc;
		cyc = 0;
		if (exp.motor_en) begin
			@(negedge sys_clk);
			while (!o_trig_convst) begin
				cyc++;
				if (cyc > GAP_LIMIT)
					fail_run("No convert pulse while the motor is enabled");
				@(negedge sys_clk);
			end
			cyc = 0;
			do begin
				@(negedge sys_clk);
				cyc++;
			end while (!o_trig_convst && cyc <= GAP_LIMIT);
			check_count("convert gap", cyc, int'(exp.voltage) * 64 + 1);
		end else begin
			repeat (QUIET_CYCLES) begin
				@(negedge sys_clk);
				check_bit("o_trig_convst", o_trig_convst, 1'b0);
			end
		end
	endtask

	//**************************************************
	// Stimulus and checks
	//**************************************************
	initial begin
		row_t       r;
		logic [1:0] resp;
		logic       ok;
		voltage_t   v;
		logic       dir;
		logic       alm;
		logic       bad;
		sys_clk   = 1'b0;
		sys_rst   = 1'b1;
		i_awvalid = 1'b0;
		i_awaddr  = '0;
		i_wvalid  = 1'b0;
		i_wdata   = '0;
		i_wstrb   = '1;
		i_bready  = 1'b0;
		i_sdo     = 1'b0;

		add_row(CMD_ADDR, cmd_word(MOTOR_ENABLE_KEY, MOTOR_FWD_KEY, ALARM_RESET_KEY, 10'd5),
			1'b0, RESP_OKAY, make_cmd(1'b1, 1'b1, 1'b1, 10'd5), 1'b1);
		add_row(CMD_ADDR, cmd_word(MOTOR_ENABLE_KEY, 16'h1EAE, 16'hAAEC, 10'd9),
			1'b1, RESP_OKAY, make_cmd(1'b1, 1'b0, 1'b0, 10'd9), 1'b0);   // Keys one bit off
		add_row(32'h0000_0010, cmd_word(16'h0000, MOTOR_FWD_KEY, ALARM_RESET_KEY, 10'd1),
			1'b0, RESP_SLVERR, make_cmd(1'b1, 1'b0, 1'b0, 10'd9), 1'b0);
		add_row(CMD_ADDR, cmd_word(16'hEAEB, MOTOR_FWD_KEY, 16'h0000, 10'h3FF),
			1'b0, RESP_OKAY, make_cmd(1'b0, 1'b1, 1'b0, 10'h3FF), 1'b1);
		add_row(CMD_ADDR, cmd_word(MOTOR_ENABLE_KEY, MOTOR_FWD_KEY, 16'h0000, 10'd2),
			1'b1, RESP_OKAY, make_cmd(1'b1, 1'b1, 1'b0, 10'd2), 1'b0);
		add_row(32'h8000_0000, cmd_word(16'h0000, 16'h0000, 16'h0000, 10'd7),
			1'b0, RESP_SLVERR, make_cmd(1'b1, 1'b1, 1'b0, 10'd2), 1'b0);
		add_row(CMD_ADDR, cmd_word(16'h0000, 16'h0000, ALARM_RESET_KEY, 10'h155),
			1'b0, RESP_OKAY, make_cmd(1'b0, 1'b0, 1'b1, 10'h155), 1'b1);  // Motor off
		// Random codes, motor stays off
		for (int i = 0; i < NUM_RAND; i++) begin
			v   = rand_code();
			dir = lfsr_bit();
			alm = lfsr_bit();
			bad = lfsr_bit();
			add_row(CMD_ADDR, cmd_word(16'h0000, dir ? MOTOR_FWD_KEY : 16'h0000,
				alm ? ALARM_RESET_KEY : 16'h0000, v), bad, RESP_OKAY,
				make_cmd(1'b0, dir, alm, v), !bad);
		end

		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		check_reset_phase();

		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			frames.delete();
			corrupt_echo = r.corrupt;
			axi_write(r.addr, r.data, (i % 2) * 4, resp);
			check_resp("o_bresp", resp, r.resp);
			check_bit("o_motor_enable", o_motor_enable, r.cmd.motor_en);
			if (r.resp == RESP_OKAY) begin
				wait_dac_done(ok);
				check_bit("o_dac_ok", ok, r.ok);
				check_count("frame count", frames.size(), 3);
				check_word("write frame", frames[0],
					{DAC_CMD_WRITE, DAC_CH_ALL, r.cmd.voltage, 6'd0});
				check_word("read frame", frames[1], {DAC_CMD_READ, DAC_CH_A, 10'd0, 6'd0});
				check_word("no-op frame", frames[2], '0);
			end else begin
				repeat (QUIET_CYCLES) begin
					@(negedge sys_clk);
					check_bit("o_sync_n", o_sync_n, 1'b1);   // No exchange starts
				end
				check_count("frame count", frames.size(), 0);
			end
			check_cmd(r.cmd);
			check_convst(r.cmd);
		end

		$display("Everything OK");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		fail_run("Watchdog expired before the test sequence finished");
	end

endmodule

// File: source/dac_ctrl_top.sv
`timescale 1ns/1ps

module dac_ctrl_top import dac_pkg::*; (
	input  logic                sys_clk,
	input  logic                sys_rst,
	// AXI4-Lite write channels
	output logic                o_awready,
	input  logic                i_awvalid,
	input  logic [ADDR_W-1:0]   i_awaddr,
	output logic                o_wready,
	input  logic                i_wvalid,
	input  logic [DATA_W-1:0]   i_wdata,
	input  logic [DATA_W/8-1:0] i_wstrb,     // Whole word always written
	output logic                o_bvalid,
	output logic [1:0]          o_bresp,
	input  logic                i_bready,
	// DAC serial port
	input  logic                i_sdo,
	output logic                o_sclk,
	output logic                o_sync_n,
	output logic                o_sdin,
	output logic                o_dac_reset_n,
	output logic                o_dac_done,
	output logic                o_dac_ok,
	// Motor side
	output logic                o_motor_enable,
	output logic                o_motor_dir,
	output logic                o_alarm_reset,
	output logic                o_trig_convst
);
	cmd_t cmd_new;
	cmd_t cmd_q;         // Applied command
	logic cmd_valid;
	logic seq_busy;
	logic sclk_rise;
	logic sclk_fall;

	dac_frame_if frame ();

	// Loads one clock after B is raised
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			cmd_q <= '{motor_en: 1'b0, motor_dir: 1'b1, alarm_rst: 1'b0, voltage: '0};
		else if (cmd_valid)
			cmd_q <= cmd_new;
	end

	assign o_motor_enable = cmd_q.motor_en;
	assign o_motor_dir    = cmd_q.motor_dir;
	assign o_alarm_reset  = cmd_q.alarm_rst;

	//************************************************
	// Instances
	//************************************************
	cmd_write_slave u_slave (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.i_awvalid(i_awvalid), .i_awaddr(i_awaddr), .o_awready(o_awready),
		.i_wvalid(i_wvalid), .i_wdata(i_wdata), .o_wready(o_wready),
		.o_bvalid(o_bvalid), .o_bresp(o_bresp), .i_bready(i_bready),
		.i_busy(seq_busy), .o_cmd(cmd_new), .o_cmd_valid(cmd_valid)
	);

	sclk_timer u_sclk (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.o_sclk(o_sclk), .o_rise(sclk_rise), .o_fall(sclk_fall)
	);

	dac_sequencer u_seq (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_rise(sclk_rise),
		.i_cmd(cmd_new), .i_cmd_valid(cmd_valid), .o_busy(seq_busy),
		.o_dac_reset_n(o_dac_reset_n), .o_dac_done(o_dac_done), .o_dac_ok(o_dac_ok),
		.frame(frame.seq)
	);

	dac_shifter u_shift (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_rise(sclk_rise), .i_fall(sclk_fall),
		.i_sdo(i_sdo), .o_sync_n(o_sync_n), .o_sdin(o_sdin), .frame(frame.shift)
	);

	convst_timer u_convst (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .i_enable(cmd_q.motor_en),
		.i_voltage(cmd_q.voltage), .o_trig(o_trig_convst)
	);

endmodule

// File: source/convst_timer.sv
`timescale 1ns/1ps

module convst_timer import dac_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,
	input  logic     i_enable,    // Motor running
	input  voltage_t i_voltage,
	output logic     o_trig       // ADC convert pulse
);
	logic [15:0] per_cnt;
	logic [15:0] term_cnt;

	// Period is voltage*64 + 1 cycles
	assign term_cnt = {i_voltage, 6'd0};

	always_ff @(posedge sys_clk) begin
		if (sys_rst || !i_enable) begin
			per_cnt <= '0;                // Restart when disabled
			o_trig  <= 1'b0;
		end else if (per_cnt == term_cnt) begin
			per_cnt <= '0;
			o_trig  <= 1'b1;
		end else begin
			per_cnt <= per_cnt + 1'b1;
			o_trig  <= 1'b0;
		end
	end

endmodule

// File: source/dac_shifter.sv
`timescale 1ns/1ps

module dac_shifter import dac_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       i_rise,
	input  logic       i_fall,
	input  logic       i_sdo,      // DAC serial output
	output logic       o_sync_n,
	output logic       o_sdin,
	dac_frame_if.shift frame
);
	logic                          active;
	logic [$clog2(FRAME_BITS)-1:0] bit_cnt;   // Bit now on sdin
	dac_word_t                     tx_q;      // Bits still to send

	//************************************************
	// Shift out on rise ticks, DAC samples on fall
	//************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			active           <= 1'b0;
			bit_cnt          <= '0;
			o_sync_n         <= 1'b1;
			o_sdin           <= 1'b0;
			frame.frame_done <= 1'b0;
		end else begin
			frame.frame_done <= 1'b0;
			if (frame.frame_start) begin
				// Arrives with the rise tick of bit 23
				active   <= 1'b1;
				bit_cnt  <= '0;
				o_sync_n <= 1'b0;
				o_sdin   <= frame.frame_word[FRAME_BITS-1];
			end else if (active) begin
				if (i_rise) begin
					o_sdin  <= tx_q[FRAME_BITS-1];
					bit_cnt <= bit_cnt + 1'b1;
				end
				if (i_fall && bit_cnt == 5'(FRAME_BITS - 1)) begin
					active           <= 1'b0;   // Last bit sampled
					o_sync_n         <= 1'b1;
					o_sdin           <= 1'b0;
					frame.frame_done <= 1'b1;
				end
			end
		end
	end

	// Transmit and receive registers, one bit per rise tick
	always_ff @(posedge sys_clk) begin
		if (frame.frame_start) begin
			tx_q           <= frame.frame_word << 1;
			frame.frame_rx <= {frame.frame_rx[FRAME_BITS-2:0], i_sdo};
		end else if (active && i_rise) begin
			tx_q           <= tx_q << 1;
			frame.frame_rx <= {frame.frame_rx[FRAME_BITS-2:0], i_sdo};
		end
	end

	// Sequencer must leave the gap before a new frame
	a_start_in_gap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		frame.frame_start |-> o_sync_n && !active);

endmodule

// File: source/dac_sequencer.sv
`timescale 1ns/1ps

module dac_sequencer import dac_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,
	input  logic     i_rise,
	input  cmd_t     i_cmd,
	input  logic     i_cmd_valid,
	output logic     o_busy,
	output logic     o_dac_reset_n,
	output logic     o_dac_done,
	output logic     o_dac_ok,
	dac_frame_if.seq frame
);
	// One-hot states
	typedef enum logic [4:0] {
		S_RESET = 5'b00001,    // DAC reset pulse
		S_IDLE  = 5'b00010,
		S_SYNC  = 5'b00100,    // sync_n gap before a frame
		S_FRAME = 5'b01000,    // Shifter busy
		S_CHECK = 5'b10000     // Compare echoed code
	} state_t;

	state_t                          state;
	logic [$clog2(SYNC_SCLKS+1)-1:0] tick_cnt;   // Rise ticks in reset or gap
	logic [1:0]                      frame_idx;  // Write, read, no-op
	voltage_t                        volt_q;

	assign o_busy = (state != S_IDLE);

	// Start on the rise tick that closes the gap
	assign frame.frame_start = (state == S_SYNC) && i_rise
		&& (tick_cnt == 4'(SYNC_SCLKS));

	//************************************************
	// Frame words, top bit first
	//************************************************
	always_comb begin
		case (frame_idx)
			2'd0:    frame.frame_word = {DAC_CMD_WRITE, DAC_CH_ALL, volt_q, 6'd0};
			2'd1:    frame.frame_word = {DAC_CMD_READ, DAC_CH_A, 10'd0, 6'd0};
			default: frame.frame_word = '0;       // No-op, clocks out the echo
		endcase
	end

	//************************************************
	// Exchange FSM
	//************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state         <= S_RESET;
			tick_cnt      <= '0;
			frame_idx     <= '0;
			o_dac_reset_n <= 1'b0;
			o_dac_done    <= 1'b0;
			o_dac_ok      <= 1'b0;
		end else begin
			o_dac_done <= 1'b0;
			case (state)
				S_RESET: begin
					if (i_rise) begin
						if (tick_cnt == 4'(RESET_SCLKS)) begin
							o_dac_reset_n <= 1'b1;   // Released at a period start
							tick_cnt      <= '0;
							state         <= S_IDLE;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				S_IDLE: begin
					if (i_cmd_valid) begin
						frame_idx <= 2'd0;
						tick_cnt  <= '0;
						state     <= S_SYNC;
					end
				end
				S_SYNC: begin
					if (frame.frame_start)
						state <= S_FRAME;
					else if (i_rise)
						tick_cnt <= tick_cnt + 1'b1;
				end
				S_FRAME: begin
					if (frame.frame_done) begin
						tick_cnt <= '0;
						if (frame_idx == 2'd2) begin
							state <= S_CHECK;      // No-op frame was last
						end else begin
							frame_idx <= frame_idx + 1'b1;
							state     <= S_SYNC;
						end
					end
				end
				S_CHECK: begin
					o_dac_ok   <= (frame.frame_rx[11:2] == volt_q);
					o_dac_done <= 1'b1;
					state      <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Voltage kept for frame build and readback compare
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && i_cmd_valid)
			volt_q <= i_cmd.voltage;
	end

	a_state_onehot: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$onehot(state));

endmodule

// File: source/sclk_timer.sv
`timescale 1ns/1ps

module sclk_timer import dac_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	output logic o_sclk,   // Free-running serial clock
	output logic o_rise,   // First cycle of sclk high
	output logic o_fall    // First cycle of sclk low
);
	logic [$clog2(SCLK_DIV)-1:0] div_cnt;
	logic [$clog2(SCLK_DIV)-1:0] div_nxt;

	// Phase 0 .. SCLK_DIV-1, wraps
	assign div_nxt = (div_cnt == SCLK_DIV - 1) ? '0 : div_cnt + 1'b1;

	//************************************************
	// Divider and edge ticks
	//************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= '0;
			o_sclk  <= 1'b0;
			o_rise  <= 1'b0;
			o_fall  <= 1'b0;
		end else begin
			div_cnt <= div_nxt;
			o_sclk  <= (div_nxt < SCLK_HIGH);   // High in phases 0..2
			o_rise  <= (div_nxt == 0);
			o_fall  <= (div_nxt == SCLK_HIGH);
		end
	end

endmodule

// File: source/cmd_write_slave.sv
`timescale 1ns/1ps

module cmd_write_slave import dac_pkg::*; (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  logic              i_awvalid,
	input  logic [ADDR_W-1:0] i_awaddr,
	output logic              o_awready,
	input  logic              i_wvalid,
	input  logic [DATA_W-1:0] i_wdata,
	output logic              o_wready,
	output logic              o_bvalid,
	output logic [1:0]        o_bresp,
	input  logic              i_bready,
	input  logic              i_busy,     // Sequencer not idle
	output cmd_t              o_cmd,
	output logic              o_cmd_valid
);
	logic              aw_got;    // Address channel done
	logic              w_got;     // Data channel done
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;
	logic              addr_hit;

	// Ready only when idle, nothing latched and no response pending
	assign o_awready = !aw_got && !o_bvalid && !i_busy;
	assign o_wready  = !w_got && !o_bvalid && !i_busy;
	assign addr_hit  = (addr_q == CMD_ADDR);

	//************************************************
	// Channel tracking and response
	//************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			aw_got      <= 1'b0;
			w_got       <= 1'b0;
			o_bvalid    <= 1'b0;
			o_bresp     <= RESP_OKAY;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;                  // Single-cycle pulse
			if (i_awvalid && o_awready)
				aw_got <= 1'b1;
			if (i_wvalid && o_wready)
				w_got <= 1'b1;
			if (aw_got && w_got) begin
				// Both halves in, launch B
				aw_got      <= 1'b0;
				w_got       <= 1'b0;
				o_bvalid    <= 1'b1;
				o_bresp     <= addr_hit ? RESP_OKAY : RESP_SLVERR;
				o_cmd_valid <= addr_hit;
			end else if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
		end
	end

	// Latched address, data and decoded keys
	always_ff @(posedge sys_clk) begin
		if (i_awvalid && o_awready)
			addr_q <= i_awaddr;
		if (i_wvalid && o_wready)
			data_q <= i_wdata;
		if (aw_got && w_got) begin
			o_cmd.motor_en  <= (data_q[63:48] == MOTOR_ENABLE_KEY);
			o_cmd.motor_dir <= (data_q[47:32] == MOTOR_FWD_KEY);
			o_cmd.alarm_rst <= (data_q[15:0] == ALARM_RESET_KEY);
			o_cmd.voltage   <= data_q[25:16];
		end
	end

	// Response held until the master takes it
	a_bvalid_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		o_bvalid && !i_bready |=> o_bvalid);

endmodule

// File: source/dac_frame_if.sv
`timescale 1ns/1ps

// Frame request and result between sequencer and shifter
interface dac_frame_if import dac_pkg::*; ();
	logic      frame_start;  // One cycle, only with a rise tick
	dac_word_t frame_word;   // Held while the frame is sent
	logic      frame_done;   // Cycle after the last fall tick
	dac_word_t frame_rx;     // Captured sdo, first bit at the top

	modport seq (
		output frame_start,
		output frame_word,
		input  frame_done,
		input  frame_rx
	);

	modport shift (
		input  frame_start,
		input  frame_word,
		output frame_done,
		output frame_rx
	);
endinterface

// File: source/dac_pkg.sv
package dac_pkg;

	//************************************************
	// AXI4-Lite command port
	//************************************************
	localparam int DATA_W = 64;                          // Write data width
	localparam int ADDR_W = 32;                          // Write address width
	localparam logic [ADDR_W-1:0] CMD_ADDR = 32'h0000_0000;

	// Write response codes
	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Command keys, one per 16-bit field
	localparam logic [15:0] MOTOR_ENABLE_KEY = 16'hEAEA; // Bits 63:48
	localparam logic [15:0] MOTOR_FWD_KEY    = 16'h1EAF; // Bits 47:32
	localparam logic [15:0] ALARM_RESET_KEY  = 16'hAAED; // Bits 15:0

	typedef logic [9:0]  voltage_t;                      // DAC code, bits 25:16
	typedef logic [23:0] dac_word_t;                     // One serial frame

	// Decoded command
	typedef struct packed {
		logic     motor_en;
		logic     motor_dir;
		logic     alarm_rst;
		voltage_t voltage;
	} cmd_t;

	//************************************************
	// DAC serial frame fields
	//************************************************
	localparam logic [3:0] DAC_CMD_WRITE = 4'd3;         // Write and update
	localparam logic [3:0] DAC_CMD_READ  = 4'd9;         // Readback request
	localparam logic [3:0] DAC_CH_ALL    = 4'd9;
	localparam logic [3:0] DAC_CH_A      = 4'd1;

	// Serial timing, in sys_clk cycles or sclk periods
	localparam int SCLK_DIV    = 5;                      // sys_clk cycles per sclk
	localparam int SCLK_HIGH   = 3;                      // sclk high for first 3 cycles
	localparam int RESET_SCLKS = 4;                      // reset_n low time
	localparam int SYNC_SCLKS  = 10;                     // sync_n high gap before a frame
	localparam int FRAME_BITS  = 24;

endpackage
